//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_branch_fetch_unit
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bp_if.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

// Fetch-side lookup, all combinational within the cycle
interface bp_lookup_if;
    logic [`BP_XLEN-1:0]  pc;
    logic                 btb_hit;
    logic                 pred_taken;
    logic [`BP_XLEN-1:0]  target;
    logic [`BP_GHR_W-1:0] ghr;

    modport fetch (
        output pc,
        input  pred_taken,
        input  target
    );

    modport predictor (
        input  pc,
        output btb_hit,
        output pred_taken,
        output target,
        output ghr
    );
endinterface

// Training strobe from the resolve logic, one write per valid cycle
interface bp_update_if;
    logic                 valid;
    logic [`BP_XLEN-1:0]  pc;
    logic [`BP_XLEN-1:0]  target;
    logic                 taken;
    logic                 is_cond;
    logic [`BP_GHR_W-1:0] ghr;

    modport resolver (
        output valid, pc, target, taken, is_cond, ghr
    );

    modport predictor (
        input  valid, pc, target, taken, is_cond, ghr
    );
endinterface

//--- bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Address and data width
`define BP_XLEN 32

// BTB index bits taken from PC[BP_BTB_IDX_W+1:2], 64 entries
`define BP_BTB_IDX_W 6

// Global history length, also the PHT index width
`define BP_GHR_W 4

// Saturating counter width
`define BP_CNT_W 2

// Tag is everything above the BTB index
`define BP_BTB_TAG_W (`BP_XLEN - `BP_BTB_IDX_W - 2)

`endif

//--- bp_pkg.sv
`include "bp_macros.svh"

package bp_pkg;

    // Kind of a resolved control transfer
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JAL  = 2'd2,
        BR_JALR = 2'd3
    } br_kind_e;

    // One BTB line
    typedef struct packed {
        logic                      valid;
        logic [`BP_BTB_TAG_W-1:0]  tag;
        logic [`BP_XLEN-1:0]       target;
    } btb_entry_t;

    // Two-bit saturating counter, MSB is the taken prediction
    typedef logic [`BP_CNT_W-1:0] pht_cnt_t;

endpackage

//--- branch_fetch_unit.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module branch_fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 fetch_en_i,

    // Resolved branch with its prediction snapshot
    input  logic                 resolve_valid_i,
    input  logic [`BP_XLEN-1:0]  resolve_pc_i,
    input  bp_pkg::br_kind_e     resolve_kind_i,
    input  logic                 resolve_taken_i,
    input  logic                 resolve_pred_taken_i,
    input  logic [`BP_XLEN-1:0]  resolve_target_i,
    input  logic [`BP_GHR_W-1:0] resolve_ghr_i,

    output logic [`BP_XLEN-1:0]  fetch_pc_o,
    output logic                 fetch_btb_hit_o,
    output logic                 fetch_pred_taken_o,
    output logic [`BP_GHR_W-1:0] fetch_ghr_o,
    output logic                 flush_o
);

    logic                redirect;
    logic [`BP_XLEN-1:0] redirect_pc;

    bp_lookup_if lookup_if ();
    bp_update_if update_if ();

    fetch_pc_gen i_fetch_pc_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_en_i    (fetch_en_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .lookup        (lookup_if.fetch)
    );

    gshare_predictor i_gshare_predictor (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .lookup (lookup_if.predictor),
        .update (update_if.predictor)
    );

    branch_resolve i_branch_resolve (
        .resolve_valid_i      (resolve_valid_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_kind_i       (resolve_kind_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_pred_taken_i (resolve_pred_taken_i),
        .resolve_target_i     (resolve_target_i),
        .resolve_ghr_i        (resolve_ghr_i),
        .update               (update_if.resolver),
        .redirect_o           (redirect),
        .redirect_pc_o        (redirect_pc),
        .clk_i                (clk_i),
        .rst_ni               (rst_ni)
    );

    // Fetch view for the downstream pipeline
    assign fetch_pc_o         = lookup_if.pc;
    assign fetch_btb_hit_o    = lookup_if.btb_hit;
    assign fetch_pred_taken_o = lookup_if.pred_taken;
    assign fetch_ghr_o        = lookup_if.ghr;
    assign flush_o            = redirect;

endmodule

//--- branch_resolve.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module branch_resolve (
    input  logic                 resolve_valid_i,
    input  logic [`BP_XLEN-1:0]  resolve_pc_i,
    input  bp_pkg::br_kind_e     resolve_kind_i,
    input  logic                 resolve_taken_i,
    input  logic                 resolve_pred_taken_i,
    input  logic [`BP_XLEN-1:0]  resolve_target_i,
    input  logic [`BP_GHR_W-1:0] resolve_ghr_i,
    bp_update_if.resolver        update,
    output logic                 redirect_o,
    output logic [`BP_XLEN-1:0]  redirect_pc_o,
    input  logic                 clk_i,
    input  logic                 rst_ni
);

    logic trainable;
    logic is_jalr;
    logic go_target;

    assign trainable = (resolve_kind_i == bp_pkg::BR_COND) ||
                       (resolve_kind_i == bp_pkg::BR_JAL);
    assign is_jalr   = (resolve_kind_i == bp_pkg::BR_JALR);

    // JALR is never predicted, so it always recovers
    assign redirect_o = resolve_valid_i &&
                        ((trainable && (resolve_pred_taken_i != resolve_taken_i)) || is_jalr);

    // Indirect jumps always go to their target
    assign go_target     = resolve_taken_i || is_jalr;
    assign redirect_pc_o = go_target ? resolve_target_i : resolve_pc_i + `BP_XLEN'd4;

    // Training strobe
    assign update.valid   = resolve_valid_i && trainable;
    assign update.pc      = resolve_pc_i;
    assign update.target  = resolve_target_i;
    assign update.taken   = resolve_taken_i;
    assign update.is_cond = trainable;
    assign update.ghr     = resolve_ghr_i;

    // A flush only comes from a real resolution, with a defined recovery address
    a_redirect_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        redirect_o |-> resolve_valid_i && !$isunknown(redirect_pc_o)
    );

endmodule

//--- fetch_pc_gen.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module fetch_pc_gen (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                fetch_en_i,
    input  logic                redirect_i,
    input  logic [`BP_XLEN-1:0] redirect_pc_i,
    bp_lookup_if.fetch          lookup
);

    logic [`BP_XLEN-1:0] pc_q;
    logic [`BP_XLEN-1:0] pc_seq;
    logic [`BP_XLEN-1:0] pc_d;

    assign pc_seq = pc_q + `BP_XLEN'd4;

    // Redirect wins over the predicted path
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (lookup.pred_taken) begin
            pc_d = lookup.target;
        end else begin
            pc_d = pc_seq;
        end
    end

    // Stalled fetch holds unless a recovery arrives
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else if (redirect_i || fetch_en_i) begin
            pc_q <= pc_d;
        end
    end

    assign lookup.pc = pc_q;

    // Targets from the BTB and the resolve path must keep word alignment
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pc_q[1:0] == 2'b00
    );

endmodule

//--- gshare_predictor.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module gshare_predictor (
    input  logic          clk_i,
    input  logic          rst_ni,
    bp_lookup_if.predictor lookup,
    bp_update_if.predictor update
);

    logic [`BP_BTB_IDX_W-1:0] btb_rd_idx;
    logic [`BP_BTB_TAG_W-1:0] btb_rd_tag;
    logic [`BP_BTB_IDX_W-1:0] btb_wr_idx;
    logic [`BP_BTB_TAG_W-1:0] btb_wr_tag;
    logic [`BP_GHR_W-1:0]     pht_rd_idx;
    logic [`BP_GHR_W-1:0]     pht_wr_idx;
    logic [`BP_GHR_W-1:0]     ghr_q;
    logic                     train;

    bp_pkg::btb_entry_t btb_rd_entry;
    bp_pkg::btb_entry_t btb_wr_entry;
    bp_pkg::pht_cnt_t   pht_rd_cnt;
    bp_pkg::pht_cnt_t   pht_old_cnt;
    bp_pkg::pht_cnt_t   pht_wr_cnt;

    // PC split for lookup and for training
    assign btb_rd_idx = lookup.pc[`BP_BTB_IDX_W+1:2];
    assign btb_rd_tag = lookup.pc[`BP_XLEN-1:`BP_BTB_IDX_W+2];
    assign btb_wr_idx = update.pc[`BP_BTB_IDX_W+1:2];
    assign btb_wr_tag = update.pc[`BP_XLEN-1:`BP_BTB_IDX_W+2];

    // Gshare hash, training uses the history snapshot of the branch
    assign pht_rd_idx = lookup.pc[`BP_GHR_W+1:2] ^ ghr_q;
    assign pht_wr_idx = update.pc[`BP_GHR_W+1:2] ^ update.ghr;

    assign train = update.valid && update.is_cond;

    pred_table #(
        .entry_t (bp_pkg::btb_entry_t),
        .IDX_W   (`BP_BTB_IDX_W)
    ) i_btb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd_idx_i       (btb_rd_idx),
        .rd_entry_o     (btb_rd_entry),
        .wr_en_i        (train && update.taken),
        .wr_idx_i       (btb_wr_idx),
        .wr_entry_i     (btb_wr_entry),
        .wr_old_entry_o ()
    );

    pred_table #(
        .entry_t (bp_pkg::pht_cnt_t),
        .IDX_W   (`BP_GHR_W)
    ) i_pht (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd_idx_i       (pht_rd_idx),
        .rd_entry_o     (pht_rd_cnt),
        .wr_en_i        (train),
        .wr_idx_i       (pht_wr_idx),
        .wr_entry_i     (pht_wr_cnt),
        .wr_old_entry_o (pht_old_cnt)
    );

    assign btb_wr_entry = '{valid: 1'b1, tag: btb_wr_tag, target: update.target};

    // Saturate at 0 and at all ones
    always_comb begin
        pht_wr_cnt = pht_old_cnt;
        if (update.taken) begin
            if (pht_old_cnt != '1) begin
                pht_wr_cnt = pht_old_cnt + 1'b1;
            end
        end else if (pht_old_cnt != '0) begin
            pht_wr_cnt = pht_old_cnt - 1'b1;
        end
    end

    // Global history, newest outcome in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (train) begin
            ghr_q <= {ghr_q[`BP_GHR_W-2:0], update.taken};
        end
    end

    assign lookup.btb_hit    = btb_rd_entry.valid && (btb_rd_entry.tag == btb_rd_tag);
    assign lookup.pred_taken = lookup.btb_hit && pht_rd_cnt[`BP_CNT_W-1];
    assign lookup.target     = btb_rd_entry.target;
    assign lookup.ghr        = ghr_q;

    // Resolve side must hand over a clean PC with every training strobe
    a_upd_pc_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        update.valid |-> !$isunknown(update.pc)
    );

endmodule

//--- pred_table.sv
`timescale 1ns/10ps

module pred_table #(
    parameter type entry_t = logic,
    parameter int  IDX_W   = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [IDX_W-1:0] rd_idx_i,
    output entry_t           rd_entry_o,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  entry_t           wr_entry_i,
    // Current content at the write index, for read-modify-write users
    output entry_t           wr_old_entry_o
);

    localparam int DEPTH = 2 ** IDX_W;

    entry_t mem_q [DEPTH];

    // Lookup port, same-cycle
    assign rd_entry_o     = mem_q[rd_idx_i];
    assign wr_old_entry_o = mem_q[wr_idx_i];

    // Whole table clears so nothing predicts out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_entry_i;
        end
    end

endmodule

//--- project.f
+incdir+.
bp_pkg.sv
bp_if.sv
pred_table.sv
gshare_predictor.sv
branch_resolve.sv
fetch_pc_gen.sv
branch_fetch_unit.sv
tb_branch_fetch_unit.sv

//--- tb_branch_fetch_unit.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module tb_branch_fetch_unit;

    // Limit in clock cycles, far above the length of all tests
    localparam int MAX_CYCLES = 2000;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 fetch_en_i;
    logic                 resolve_valid_i;
    logic [`BP_XLEN-1:0]  resolve_pc_i;
    bp_pkg::br_kind_e     resolve_kind_i;
    logic                 resolve_taken_i;
    logic                 resolve_pred_taken_i;
    logic [`BP_XLEN-1:0]  resolve_target_i;
    logic [`BP_GHR_W-1:0] resolve_ghr_i;
    logic [`BP_XLEN-1:0]  fetch_pc_o;
    logic                 fetch_btb_hit_o;
    logic                 fetch_pred_taken_o;
    logic [`BP_GHR_W-1:0] fetch_ghr_o;
    logic                 flush_o;

    // Reference model of BTB, counters and history
    logic                     m_valid [2**`BP_BTB_IDX_W];
    logic [`BP_BTB_TAG_W-1:0] m_tag   [2**`BP_BTB_IDX_W];
    logic [`BP_XLEN-1:0]      m_tgt   [2**`BP_BTB_IDX_W];
    logic [1:0]               m_cnt   [2**`BP_GHR_W];
    logic [`BP_GHR_W-1:0]     m_ghr;

    logic [`BP_XLEN-1:0] trained_pc;
    logic [`BP_XLEN-1:0] trained_tgt;
    int errors = 0;
    int tests  = 0;
    int cycles = 0;

    branch_fetch_unit i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [`BP_XLEN-1:0] rand_pc();
        return $urandom & 32'hFFFF_FFFC;
    endfunction

    function automatic logic model_hit(input logic [`BP_XLEN-1:0] pc);
        return m_valid[pc[`BP_BTB_IDX_W+1:2]] &&
               (m_tag[pc[`BP_BTB_IDX_W+1:2]] == pc[`BP_XLEN-1:`BP_BTB_IDX_W+2]);
    endfunction

    function automatic logic model_pred(input logic [`BP_XLEN-1:0] pc);
        return model_hit(pc) && m_cnt[pc[`BP_GHR_W+1:2] ^ m_ghr][1];
    endfunction

    // Training rules for conditional branches and JAL only
    function automatic void model_train(input logic [`BP_XLEN-1:0] pc,
                                        input bp_pkg::br_kind_e kind, input logic taken,
                                        input logic [`BP_XLEN-1:0] target,
                                        input logic [`BP_GHR_W-1:0] ghr);
        logic [`BP_GHR_W-1:0]     pi;
        logic [`BP_BTB_IDX_W-1:0] bi;
        pi = pc[`BP_GHR_W+1:2] ^ ghr;
        bi = pc[`BP_BTB_IDX_W+1:2];
        if (kind == bp_pkg::BR_COND || kind == bp_pkg::BR_JAL) begin
            if (taken && m_cnt[pi] != 2'd3) begin
                m_cnt[pi] = m_cnt[pi] + 2'd1;
            end else if (!taken && m_cnt[pi] != 2'd0) begin
                m_cnt[pi] = m_cnt[pi] - 2'd1;
            end
            if (taken) begin
                m_valid[bi] = 1'b1;
                m_tag[bi]   = pc[`BP_XLEN-1:`BP_BTB_IDX_W+2];
                m_tgt[bi]   = target;
            end
            m_ghr = {m_ghr[`BP_GHR_W-2:0], taken};
        end
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%-28s %s", name, (errors == errs_before) ? "passed" : "failed");
    endtask

    // One resolution cycle, then checks of flush, recovery PC and history
    task automatic apply_resolution(input logic [`BP_XLEN-1:0] pc, input bp_pkg::br_kind_e kind,
                                    input logic taken, input logic pred,
                                    input logic [`BP_XLEN-1:0] target,
                                    input logic [`BP_GHR_W-1:0] ghr);
        logic                mispred;
        logic [`BP_XLEN-1:0] exp_pc;
        mispred = (kind == bp_pkg::BR_JALR) ||
                  ((kind == bp_pkg::BR_COND || kind == bp_pkg::BR_JAL) && pred != taken);
        @(posedge clk_i);
        resolve_valid_i      <= 1'b1;
        resolve_pc_i         <= pc;
        resolve_kind_i       <= kind;
        resolve_taken_i      <= taken;
        resolve_pred_taken_i <= pred;
        resolve_target_i     <= target;
        resolve_ghr_i        <= ghr;
        @(negedge clk_i);
        exp_pc = mispred ? (taken ? target : pc + 32'd4) : fetch_pc_o;
        check_word(32'(flush_o), 32'(mispred), "flush_o");
        @(posedge clk_i);
        resolve_valid_i <= 1'b0;
        model_train(pc, kind, taken, target, ghr);
        @(negedge clk_i);
        check_word(fetch_pc_o, exp_pc, "fetch_pc_o after resolution");
        check_word(32'(fetch_ghr_o), 32'(m_ghr), "fetch_ghr_o");
    endtask

    // A JALR steers fetch without touching the tables
    task automatic redirect_fetch(input logic [`BP_XLEN-1:0] pc);
        apply_resolution(32'h0, bp_pkg::BR_JALR, 1'b1, 1'b0, pc, m_ghr);
    endtask

    task automatic test_reset_seq();
        int                  e0;
        logic [`BP_XLEN-1:0] exp;
        e0  = errors;
        exp = '0;
        @(negedge clk_i);
        check_word(fetch_pc_o, exp, "fetch_pc_o after reset");
        check_word(32'(flush_o), 32'd0, "flush_o after reset");
        @(posedge clk_i);
        fetch_en_i <= 1'b1;
        repeat (8) begin
            @(posedge clk_i);
            @(negedge clk_i);
            exp += 32'd4;
            check_word(fetch_pc_o, exp, "sequential fetch_pc_o");
            check_word(32'(fetch_btb_hit_o), 32'd0, "fetch_btb_hit_o");
            check_word(32'(fetch_pred_taken_o), 32'd0, "fetch_pred_taken_o");
        end
        @(posedge clk_i);
        fetch_en_i <= 1'b0;
        @(negedge clk_i);
        exp += 32'd4;
        check_word(fetch_pc_o, exp, "last sequential fetch_pc_o");
        report_test("reset and sequential fetch", e0);
    endtask

    task automatic test_stall();
        int                  e0;
        logic [`BP_XLEN-1:0] held;
        e0   = errors;
        held = fetch_pc_o;
        repeat (5) begin
            @(negedge clk_i);
            check_word(fetch_pc_o, held, "stalled fetch_pc_o");
        end
        report_test("stall", e0);
    endtask

    task automatic test_train_taken();
        int                   e0;
        logic [`BP_XLEN-1:0]  exp;
        logic [`BP_GHR_W-1:0] g;
        e0          = errors;
        trained_pc  = rand_pc();
        trained_tgt = rand_pc();
        // Snapshot equal to the history seen at lookup after both taken outcomes
        g = {m_ghr[`BP_GHR_W-3:0], 2'b11};
        repeat (2) begin
            apply_resolution(trained_pc, bp_pkg::BR_COND, 1'b1, 1'b0, trained_tgt, g);
        end
        redirect_fetch(trained_pc);
        check_word(32'(fetch_btb_hit_o), 32'(model_hit(trained_pc)), "fetch_btb_hit_o");
        check_word(32'(fetch_pred_taken_o), 32'(model_pred(trained_pc)), "fetch_pred_taken_o");
        check_word(32'(fetch_pred_taken_o), 32'd1, "fetch_pred_taken_o after two taken trainings");
        exp = model_pred(trained_pc) ? m_tgt[trained_pc[`BP_BTB_IDX_W+1:2]] :
                                       trained_pc + 32'd4;
        @(posedge clk_i);
        fetch_en_i <= 1'b1;
        @(posedge clk_i);
        fetch_en_i <= 1'b0;
        @(negedge clk_i);
        check_word(fetch_pc_o, exp, "fetch_pc_o after predicted fetch");
        report_test("training and taken predict", e0);
    endtask

    task automatic test_mispredict();
        int                  e0;
        logic [`BP_XLEN-1:0] q;
        logic [`BP_XLEN-1:0] u;
        e0 = errors;
        q  = rand_pc();
        u  = rand_pc();
        apply_resolution(q, bp_pkg::BR_COND, 1'b1, 1'b0, u, m_ghr);
        apply_resolution(q, bp_pkg::BR_COND, 1'b0, 1'b1, u, m_ghr);
        report_test("misprediction recovery", e0);
    endtask

    task automatic test_indirect();
        int                   e0;
        logic [`BP_GHR_W-1:0] g;
        logic [`BP_XLEN-1:0]  r;
        logic [`BP_XLEN-1:0]  v;
        e0 = errors;
        g  = m_ghr;
        r  = rand_pc();
        v  = rand_pc();
        apply_resolution(r, bp_pkg::BR_JALR, 1'b1, 1'b0, v, m_ghr);
        check_word(32'(fetch_ghr_o), 32'(g), "fetch_ghr_o after JALR");
        report_test("indirect jump", e0);
    endtask

    task automatic test_alias_saturate();
        int e0;
        e0 = errors;
        // Same index with the tag flipped in bit 20
        redirect_fetch(trained_pc ^ 32'h0010_0000);
        check_word(32'(fetch_btb_hit_o), 32'd0, "fetch_btb_hit_o on aliased tag");
        check_word(32'(fetch_pred_taken_o), 32'd0, "fetch_pred_taken_o on aliased tag");
        // Zero snapshot so the drained counter is the one looked up later
        repeat (5) begin
            apply_resolution(trained_pc, bp_pkg::BR_COND, 1'b0, 1'b0, trained_tgt, '0);
        end
        redirect_fetch(trained_pc);
        check_word(32'(fetch_btb_hit_o), 32'(model_hit(trained_pc)), "fetch_btb_hit_o");
        check_word(32'(fetch_pred_taken_o), 32'(model_pred(trained_pc)), "fetch_pred_taken_o");
        check_word(32'(fetch_pred_taken_o), 32'd0, "fetch_pred_taken_o after saturation");
        report_test("tag aliasing and saturation", e0);
    endtask

    initial begin
        void'($urandom(32'ha684));
        rst_ni               = 1'b0;
        fetch_en_i           = 1'b0;
        resolve_valid_i      = 1'b0;
        resolve_pc_i         = '0;
        resolve_kind_i       = bp_pkg::BR_NONE;
        resolve_taken_i      = 1'b0;
        resolve_pred_taken_i = 1'b0;
        resolve_target_i     = '0;
        resolve_ghr_i        = '0;
        m_ghr                = '0;
        for (int i = 0; i < 2**`BP_BTB_IDX_W; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_tgt[i]   = '0;
        end
        for (int i = 0; i < 2**`BP_GHR_W; i++) begin
            m_cnt[i] = 2'd0;
        end
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_reset_seq();
        test_stall();
        test_train_taken();
        test_mispredict();
        test_indirect();
        test_alias_saturate();

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
